/* mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

////////////////////
// Data path sizes
////////////////////

// Width of one memory word in bits
`define MEM_DATA_WIDTH 32

// Word index bits, 1024 words of RAM
`define MEM_WORD_BITS 10

////////////////////
// Address map
////////////////////

// Low address bits that fall inside the RAM window (4 KiB)
`define MEM_WIN_BITS 12

// Data region base after reset
`define MEM_BASE_RESET 32'h0001_0000

`endif

/* riscv_ctrl_pkg.sv */
`default_nettype none

package riscv_ctrl_pkg;

    ////////////////////
    // Instruction class
    ////////////////////

    typedef enum logic [1:0] {
        NONE  = 2'd0,   // No memory access
        LOAD  = 2'd1,
        STORE = 2'd2
    } inst_class_t;

    ////////////////////
    // Memory sub-operation
    ////////////////////

    // Unsigned variants only matter for loads
    // On stores UBYTE and UHALF write like BYTE and HALF
    typedef enum logic [2:0] {
        BYTE  = 3'd0,   // Sign extended on load
        HALF  = 3'd1,   // Sign extended on load
        WORD  = 3'd2,
        UBYTE = 3'd3,   // Zero extended on load
        UHALF = 3'd4    // Zero extended on load
    } mem_op_t;

endpackage

`default_nettype wire

/* mem_bus_pkg.sv */
`default_nettype none

`include "mem_defs.svh"

package mem_bus_pkg;

    // One enable per byte lane
    typedef logic [`MEM_DATA_WIDTH/8-1:0] byte_en_t;

    // A word seen as its byte lanes, lane 0 is the lowest address
    typedef logic [`MEM_DATA_WIDTH/8-1:0][7:0] lane_data_t;

    ////////////////////
    // Config registers
    ////////////////////

    typedef enum logic [1:0] {
        CFG_BASE       = 2'd0,  // RAM window base
        CFG_CTRL       = 2'd1,  // Bit 0 is strict alignment
        CFG_FAULT_CNT  = 2'd2,  // Write clears
        CFG_FAULT_ADDR = 2'd3   // Read only
    } cfg_reg_t;

endpackage

`default_nettype wire

/* access_aligner.sv */
`default_nettype none

`include "mem_defs.svh"

module access_aligner (
    input  logic                         mem_en,
    input  riscv_ctrl_pkg::inst_class_t  inst_class,
    input  riscv_ctrl_pkg::mem_op_t      mem_op,
    input  logic [31:0]                  addr,
    input  logic [`MEM_DATA_WIDTH-1:0]   wdata,
    input  logic [31:0]                  win_base,
    input  logic                         strict_align,
    output logic [`MEM_WORD_BITS-1:0]    word_idx,
    output mem_bus_pkg::byte_en_t        byte_en,
    output mem_bus_pkg::lane_data_t      lane_wdata,
    output logic                         load_go,
    output logic [1:0]                   load_off,
    output riscv_ctrl_pkg::mem_op_t      load_op,
    output logic                         fault_now
);

    logic is_half;     // HALF or UHALF
    logic is_word;     // WORD and any unknown encoding
    logic is_access;
    logic in_win;
    logic misalign;
    logic legal;
    logic [1:0] off;   // Offset after natural alignment

    ////////////////////
    // Access size decode
    ////////////////////

    always_comb begin
        is_half = 1'b0;
        is_word = 1'b0;
        case (mem_op)
            riscv_ctrl_pkg::BYTE,
            riscv_ctrl_pkg::UBYTE: ;
            riscv_ctrl_pkg::HALF,
            riscv_ctrl_pkg::UHALF: is_half = 1'b1;
            default:               is_word = 1'b1;
        endcase
    end

    ////////////////////
    // Fault decision
    ////////////////////

    assign is_access = mem_en && (inst_class == riscv_ctrl_pkg::LOAD ||
                                  inst_class == riscv_ctrl_pkg::STORE);

    // Upper bits must match the window base
    assign in_win = (addr[31:`MEM_WIN_BITS] == win_base[31:`MEM_WIN_BITS]);

    assign misalign = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));

    assign fault_now = is_access && (!in_win || (strict_align && misalign));
    assign legal     = is_access && !fault_now;

    // Relaxed mode drops the low bits down to natural alignment
    assign off = is_word ? 2'b00 : is_half ? {addr[1], 1'b0} : addr[1:0];

    assign word_idx = addr[`MEM_WORD_BITS+1:2];

    ////////////////////
    // Store lanes
    ////////////////////

    always_comb begin
        byte_en    = '0;
        lane_wdata = wdata;                                  // Word store as is
        if (is_half) begin
            lane_wdata = {2{wdata[15:0]}};                   // Half in both halves
        end else if (!is_word) begin
            lane_wdata = {4{wdata[7:0]}};                    // Byte in every lane
        end
        if (legal && inst_class == riscv_ctrl_pkg::STORE) begin
            if (is_word) begin
                byte_en = 4'b1111;
            end else if (is_half) begin
                byte_en = 4'b0011 << off;
            end else begin
                byte_en = 4'b0001 << off;
            end
        end
    end

    // Load context for the extender
    assign load_go  = legal && (inst_class == riscv_ctrl_pkg::LOAD);
    assign load_off = off;
    assign load_op  = mem_op;

endmodule

`default_nettype wire

/* data_ram.sv */
`default_nettype none

`include "mem_defs.svh"

module data_ram (
    input  logic                       clk,
    input  mem_bus_pkg::byte_en_t      byte_en,
    input  logic [`MEM_WORD_BITS-1:0]  word_idx,
    input  mem_bus_pkg::lane_data_t    lane_wdata,
    output mem_bus_pkg::lane_data_t    rdata
);

    ////////////////////
    // Storage
    ////////////////////

    // Contents are undefined until written
    mem_bus_pkg::lane_data_t mem [2**`MEM_WORD_BITS];

    ////////////////////
    // Write and read port
    ////////////////////

    // Each lane has its own write enable
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < `MEM_DATA_WIDTH/8; lane++) begin
            if (byte_en[lane]) begin
                mem[word_idx][lane] <= lane_wdata[lane];
            end
        end
    end

    // Read every cycle, old data on a same cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[word_idx];
    end

endmodule

`default_nettype wire

/* load_extender.sv */
`default_nettype none

`include "mem_defs.svh"

module load_extender (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_go,
    input  logic [1:0]                  load_off,
    input  riscv_ctrl_pkg::mem_op_t     load_op,
    input  mem_bus_pkg::lane_data_t     rdata,
    output logic [`MEM_DATA_WIDTH-1:0]  load_data,
    output logic                        load_valid
);

    logic                        pend_valid;   // RAM read in progress
    logic [1:0]                  pend_off;
    riscv_ctrl_pkg::mem_op_t     pend_op;
    logic [7:0]                  sel_byte;
    logic [15:0]                 sel_half;
    logic [`MEM_DATA_WIDTH-1:0]  ext_data;

    ////////////////////
    // Load context
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            pend_valid <= load_go;
            load_valid <= pend_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_go) begin
            pend_off <= load_off;
            pend_op  <= load_op;
        end
        if (pend_valid) begin
            load_data <= ext_data;   // Holds until the next load
        end
    end

    ////////////////////
    // Lane select and extension
    ////////////////////

    assign sel_byte = rdata[pend_off];
    assign sel_half = pend_off[1] ? {rdata[3], rdata[2]} : {rdata[1], rdata[0]};

    always_comb begin
        case (pend_op)
            riscv_ctrl_pkg::BYTE:  ext_data = {{(`MEM_DATA_WIDTH-8){sel_byte[7]}}, sel_byte};
            riscv_ctrl_pkg::UBYTE: ext_data = {{(`MEM_DATA_WIDTH-8){1'b0}}, sel_byte};
            riscv_ctrl_pkg::HALF:  ext_data = {{(`MEM_DATA_WIDTH-16){sel_half[15]}}, sel_half};
            riscv_ctrl_pkg::UHALF: ext_data = {{(`MEM_DATA_WIDTH-16){1'b0}}, sel_half};
            default:               ext_data = rdata;
        endcase
    end

endmodule

`default_nettype wire

/* mem_cfg_regs.sv */
`default_nettype none

`include "mem_defs.svh"

module mem_cfg_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_we,
    input  mem_bus_pkg::cfg_reg_t  cfg_addr,
    input  logic [31:0]            cfg_wdata,
    input  logic                   fault_now,
    input  logic [31:0]            addr,
    output logic [31:0]            cfg_rdata,
    output logic [31:0]            win_base,
    output logic                   strict_align,
    output logic                   fault
);

    logic [31:0] fault_cnt;
    logic [31:0] fault_addr;
    logic        fault_pend;   // Fault seen at the access edge
    logic        cnt_clear;

    assign cnt_clear = cfg_we && (cfg_addr == mem_bus_pkg::CFG_FAULT_CNT);

    ////////////////////
    // Control registers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_base     <= `MEM_BASE_RESET;
            strict_align <= 1'b1;
        end else if (cfg_we) begin
            case (cfg_addr)
                mem_bus_pkg::CFG_BASE: win_base     <= cfg_wdata;
                mem_bus_pkg::CFG_CTRL: strict_align <= cfg_wdata[0];
                default: ;                            // Status writes handled below
            endcase
        end
    end

    ////////////////////
    // Fault status
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_pend <= 1'b0;
            fault      <= 1'b0;
            fault_cnt  <= '0;
            fault_addr <= '0;
        end else begin
            fault_pend <= fault_now;
            fault      <= fault_pend;                 // One cycle pulse, in step with load_valid
            if (cnt_clear) begin
                fault_cnt <= {31'd0, fault_now};      // A fault in the clear cycle still counts
            end else if (fault_now && fault_cnt != '1) begin
                fault_cnt <= fault_cnt + 32'd1;       // Saturates at all ones
            end
            if (fault_now) begin
                fault_addr <= addr;
            end
        end
    end

    // Read mux
    always_comb begin
        case (cfg_addr)
            mem_bus_pkg::CFG_BASE:      cfg_rdata = win_base;
            mem_bus_pkg::CFG_CTRL:      cfg_rdata = {31'd0, strict_align};
            mem_bus_pkg::CFG_FAULT_CNT: cfg_rdata = fault_cnt;
            default:                    cfg_rdata = fault_addr;
        endcase
    end

endmodule

`default_nettype wire

/* data_mem_unit.sv */
`default_nettype none

`include "mem_defs.svh"

module data_mem_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mem_en,
    input  riscv_ctrl_pkg::inst_class_t  inst_class,
    input  riscv_ctrl_pkg::mem_op_t      mem_op,
    input  logic [31:0]                  addr,
    input  logic [`MEM_DATA_WIDTH-1:0]   wdata,
    input  logic                         cfg_we,
    input  mem_bus_pkg::cfg_reg_t        cfg_addr,
    input  logic [31:0]                  cfg_wdata,
    output logic [31:0]                  cfg_rdata,
    output logic [`MEM_DATA_WIDTH-1:0]   load_data,
    output logic                         load_valid,
    output logic                         fault
);

    logic [`MEM_WORD_BITS-1:0]  word_idx;
    mem_bus_pkg::byte_en_t      byte_en;
    mem_bus_pkg::lane_data_t    lane_wdata;
    mem_bus_pkg::lane_data_t    rdata;
    logic                       load_go;
    logic [1:0]                 load_off;
    riscv_ctrl_pkg::mem_op_t    load_op;
    logic                       fault_now;
    logic [31:0]                win_base;
    logic                       strict_align;

    ////////////////////
    // Access path
    ////////////////////

    access_aligner u_aligner (
        .mem_en       (mem_en),
        .inst_class   (inst_class),
        .mem_op       (mem_op),
        .addr         (addr),
        .wdata        (wdata),
        .win_base     (win_base),
        .strict_align (strict_align),
        .word_idx     (word_idx),
        .byte_en      (byte_en),
        .lane_wdata   (lane_wdata),
        .load_go      (load_go),
        .load_off     (load_off),
        .load_op      (load_op),
        .fault_now    (fault_now)
    );

    data_ram u_ram (
        .clk        (clk),
        .byte_en    (byte_en),
        .word_idx   (word_idx),
        .lane_wdata (lane_wdata),
        .rdata      (rdata)
    );

    load_extender u_extender (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_go    (load_go),
        .load_off   (load_off),
        .load_op    (load_op),
        .rdata      (rdata),
        .load_data  (load_data),
        .load_valid (load_valid)
    );

    ////////////////////
    // Configuration
    ////////////////////

    mem_cfg_regs u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .fault_now    (fault_now),
        .addr         (addr),
        .cfg_rdata    (cfg_rdata),
        .win_base     (win_base),
        .strict_align (strict_align),
        .fault        (fault)
    );

endmodule

`default_nettype wire

/* data_mem_unit_props.sv */
`default_nettype none

module data_mem_unit_props (
    input logic clk,
    input logic rst_n,
    input logic mem_en,
    input logic load_go,
    input logic fault_now,
    input logic load_valid,
    input logic fault
);

    logic strobe_seen;   // Any strobe since reset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_seen <= 1'b0;
        end else if (mem_en) begin
            strobe_seen <= 1'b1;
        end
    end

    ////////////////////
    // Output pulses
    ////////////////////

    // A faulting access never returns data
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_valid && fault))
        else $error("load_valid and fault high together");

    // Result comes one cycle after the RAM read
    a_valid_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid |-> $past(load_go, 2))
        else $error("load_valid without a legal load strobe");

    a_load_gives_valid: assert property (@(posedge clk) disable iff (!rst_n)
        load_go |-> ##2 load_valid)
        else $error("legal load strobe gave no load_valid");

    // Quiet outputs from reset until the first strobe
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !strobe_seen |-> !load_valid && !fault)
        else $error("pulse after reset before any strobe");

    ////////////////////
    // Fault rule
    ////////////////////

    a_fault_source: assert property (@(posedge clk) disable iff (!rst_n)
        fault |-> $past(fault_now, 2))
        else $error("fault pulse without a faulting strobe");

endmodule

bind data_mem_unit data_mem_unit_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_en     (mem_en),
    .load_go    (load_go),
    .fault_now  (fault_now),
    .load_valid (load_valid),
    .fault      (fault)
);

`default_nettype wire

/* data_mem_unit_tb.sv */
`default_nettype none

`include "mem_defs.svh"

module data_mem_unit_tb;

    localparam int RESET_CYCLES  = 10;
    localparam int WAIT_LIMIT    = 3;                    // Negedges to wait for a pulse
    localparam int ACCESS_COUNT  = 90;                   // All tests, rounded up
    localparam int ACCESS_CYCLES = WAIT_LIMIT + 3;
    localparam int CFG_COUNT     = 16;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES
                                    + CFG_COUNT * 2) * 10 + 500;

    logic                         clk;
    logic                         rst_n;
    logic                         mem_en;
    riscv_ctrl_pkg::inst_class_t  inst_class;
    riscv_ctrl_pkg::mem_op_t      mem_op;
    logic [31:0]                  addr;
    logic [31:0]                  wdata;
    logic                         cfg_we;
    mem_bus_pkg::cfg_reg_t        cfg_addr;
    logic [31:0]                  cfg_wdata;
    logic [31:0]                  cfg_rdata;
    logic [31:0]                  load_data;
    logic                         load_valid;
    logic                         fault;

    logic [7:0]  ref_mem [0:(1 << `MEM_WIN_BITS)-1];    // Byte model of the window
    logic [31:0] tb_base;
    logic        tb_strict;
    integer      seed;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_failed;

    // Word strobes for back to back bursts
    riscv_ctrl_pkg::inst_class_t  burst_cls  [16];
    logic [31:0]                  burst_addr [16];
    logic [31:0]                  burst_data [16];

    data_mem_unit uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_en     (mem_en),
        .inst_class (inst_class),
        .mem_op     (mem_op),
        .addr       (addr),
        .wdata      (wdata),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .load_data  (load_data),
        .load_valid (load_valid),
        .fault      (fault)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [31:0] natural_addr(input logic [31:0] a,
                                                 input riscv_ctrl_pkg::mem_op_t op);
        case (op)
            riscv_ctrl_pkg::WORD:  return {a[31:2], 2'b00};
            riscv_ctrl_pkg::HALF,
            riscv_ctrl_pkg::UHALF: return {a[31:1], 1'b0};
            default:               return a;
        endcase
    endfunction

    function automatic logic is_fault(input logic [31:0] a, input riscv_ctrl_pkg::mem_op_t op);
        logic mis;
        case (op)
            riscv_ctrl_pkg::HALF,
            riscv_ctrl_pkg::UHALF: mis = a[0];
            riscv_ctrl_pkg::BYTE,
            riscv_ctrl_pkg::UBYTE: mis = 1'b0;
            default:               mis = (a[1:0] != 2'b00);
        endcase
        return (a[31:`MEM_WIN_BITS] != tb_base[31:`MEM_WIN_BITS]) || (tb_strict && mis);
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] a,
                                                input riscv_ctrl_pkg::mem_op_t op);
        logic [31:0]              na;
        logic [`MEM_WIN_BITS-1:0] i;
        logic [7:0]               b;
        logic [15:0]              h;
        na = natural_addr(a, op);
        i  = na[`MEM_WIN_BITS-1:0];
        b  = ref_mem[i];
        h  = {ref_mem[i+1], ref_mem[i]};
        case (op)
            riscv_ctrl_pkg::BYTE:  return {{24{b[7]}}, b};
            riscv_ctrl_pkg::UBYTE: return {24'd0, b};
            riscv_ctrl_pkg::HALF:  return {{16{h[15]}}, h};
            riscv_ctrl_pkg::UHALF: return {16'd0, h};
            default:               return {ref_mem[i+3], ref_mem[i+2], h};
        endcase
    endfunction

    function automatic void store_model(input logic [31:0] a, input riscv_ctrl_pkg::mem_op_t op,
                                        input logic [31:0] d);
        logic [31:0]              na;
        logic [`MEM_WIN_BITS-1:0] i;
        na = natural_addr(a, op);
        i  = na[`MEM_WIN_BITS-1:0];
        ref_mem[i] = d[7:0];                             // Lowest lane always written
        if (op != riscv_ctrl_pkg::BYTE && op != riscv_ctrl_pkg::UBYTE) begin
            ref_mem[i+1] = d[15:8];
        end
        if (op == riscv_ctrl_pkg::WORD) begin
            ref_mem[i+2] = d[23:16];
            ref_mem[i+3] = d[31:24];
        end
    endfunction

    ////////////////////
    // Helpers
    ////////////////////

    task automatic report_error(input bit wrong_value, input string msg);
        if (wrong_value) begin
            $display("Fail at time %0t: %s", $time, msg);
        end else begin
            $display("%s (at time %0t)", msg, $time);
        end
        errors++;
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, test_errs);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic cfg_write(input mem_bus_pkg::cfg_reg_t reg_id, input logic [31:0] data);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = reg_id;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic cfg_read(input mem_bus_pkg::cfg_reg_t reg_id, output logic [31:0] data);
        @(negedge clk);
        cfg_addr = reg_id;
        #1 data = cfg_rdata;                             // Combinational read
    endtask

    // Drives one strobe, waits for its pulse and checks it against the model
    task automatic access(input riscv_ctrl_pkg::inst_class_t cls,
                          input riscv_ctrl_pkg::mem_op_t op,
                          input logic [31:0] a, input logic [31:0] d);
        logic        exp_f;
        logic [31:0] exp_d;
        logic        got_v;
        logic        got_f;
        logic [31:0] got_d;
        int          waited;
        exp_f = is_fault(a, op);
        exp_d = expect_load(a, op);
        @(negedge clk);
        mem_en     = 1'b1;
        inst_class = cls;
        mem_op     = op;
        addr       = a;
        wdata      = d;
        @(negedge clk);
        mem_en     = 1'b0;
        inst_class = riscv_ctrl_pkg::NONE;
        got_v  = 1'b0;
        got_f  = 1'b0;
        got_d  = '0;
        waited = 0;
        while (waited < WAIT_LIMIT) begin
            got_v = load_valid;
            got_f = fault;
            got_d = load_data;
            if (got_v || got_f) begin
                break;
            end
            @(negedge clk);
            waited++;
        end
        if (exp_f) begin
            if (!got_f) begin
                report_error(0, $sformatf("No fault pulse for access at %h", a));
            end
            if (got_v) begin
                report_error(0, $sformatf("Faulting load at %h gave load_valid", a));
            end
        end else begin
            if (got_f) begin
                report_error(0, $sformatf("Unexpected fault for access at %h", a));
            end
            if (cls == riscv_ctrl_pkg::LOAD) begin
                if (!got_v) begin
                    report_error(0, $sformatf("No load_valid for load at %h", a));
                end else if (got_d !== exp_d) begin
                    report_error(1, $sformatf("load at %h op %0d gave %h, expected %h",
                                              a, op, got_d, exp_d));
                end
            end else begin
                store_model(a, op, d);
            end
        end
    endtask

    // Drives n word strobes on consecutive cycles, each load result is due
    // two negedges after its strobe
    task automatic word_burst(input int n);
        logic [31:0] exp_d [16];
        int          due   [16];
        int          head;
        int          tail;
        head = 0;
        tail = 0;
        for (int cyc = 0; cyc < n + 2; cyc++) begin
            @(negedge clk);
            if (fault !== 1'b0) begin
                report_error(0, "Unexpected fault during a word burst");
            end
            if (head < tail && due[head] == cyc) begin
                if (load_valid !== 1'b1) begin
                    report_error(0, $sformatf("No load_valid in time for burst load %0d", head));
                end else if (load_data !== exp_d[head]) begin
                    report_error(1, $sformatf("burst load %0d gave %h, expected %h",
                                              head, load_data, exp_d[head]));
                end
                head++;
            end else if (load_valid !== 1'b0) begin
                report_error(0, "load_valid in a cycle with no burst load due");
            end
            if (cyc < n) begin
                mem_en     = 1'b1;
                inst_class = burst_cls[cyc];
                mem_op     = riscv_ctrl_pkg::WORD;
                addr       = burst_addr[cyc];
                wdata      = burst_data[cyc];
                if (burst_cls[cyc] == riscv_ctrl_pkg::STORE) begin
                    store_model(burst_addr[cyc], riscv_ctrl_pkg::WORD, burst_data[cyc]);
                end else begin
                    exp_d[tail] = expect_load(burst_addr[cyc], riscv_ctrl_pkg::WORD);
                    due[tail]   = cyc + 2;
                    tail++;
                end
            end else begin
                mem_en     = 1'b0;
                inst_class = riscv_ctrl_pkg::NONE;
            end
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_word_rw();
        // Each store is followed by its load in the very next cycle
        for (int k = 0; k < 8; k++) begin
            burst_cls[2*k]    = riscv_ctrl_pkg::STORE;
            burst_addr[2*k]   = tb_base | ($random(seed) & 32'h0000_0ffc);
            burst_data[2*k]   = $random(seed);
            burst_cls[2*k+1]  = riscv_ctrl_pkg::LOAD;
            burst_addr[2*k+1] = burst_addr[2*k];
            burst_data[2*k+1] = '0;
        end
        word_burst(16);
        // All read back on consecutive cycles, two loads in flight
        for (int k = 0; k < 8; k++) begin
            burst_cls[k]  = riscv_ctrl_pkg::LOAD;
            burst_addr[k] = burst_addr[2*k];
            burst_data[k] = '0;
        end
        word_burst(8);
        finish_test("word store and load");
    endtask

    task automatic test_sub_word();
        logic [31:0] a;
        a = tb_base + 32'h100;
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, a, $random(seed));
        for (int off = 0; off < 4; off++) begin
            access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::BYTE, a + off, $random(seed));
            access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, a, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::HALF, a + off, $random(seed));
            access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, a, 32'h0);
        end
        // Unsigned store variants write like the signed ones
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::UBYTE, a + 1, $random(seed));
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::UHALF, a + 2, $random(seed));
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, a, 32'h0);
        finish_test("byte and halfword stores");
    endtask

    task automatic test_extension();
        logic [31:0] a;
        a = tb_base + 32'h180;
        for (int pass = 0; pass < 2; pass++) begin
            // Together the two patterns give every lane a set and a clear top bit
            access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, a,
                   (pass == 0) ? 32'h8001_7f92 : 32'h7ffe_806d);
            for (int off = 0; off < 4; off++) begin
                access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::BYTE, a + off, 32'h0);
                access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::UBYTE, a + off, 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::HALF, a + off, 32'h0);
                access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::UHALF, a + off, 32'h0);
            end
        end
        finish_test("sign and zero extension");
    endtask

    task automatic test_strict();
        logic [31:0] a;
        logic [31:0] cnt0;
        logic [31:0] cnt1;
        logic [31:0] faddr;
        cfg_write(mem_bus_pkg::CFG_CTRL, 32'h1);
        tb_strict = 1'b1;
        a = tb_base + 32'h200;
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, a, 32'h1234_5678);
        cfg_read(mem_bus_pkg::CFG_FAULT_CNT, cnt0);
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::HALF, a + 1, 32'h0000_abcd);
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, a + 2, 32'h0);
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::UHALF, a + 3, 32'h0);
        cfg_read(mem_bus_pkg::CFG_FAULT_CNT, cnt1);
        if (cnt1 !== cnt0 + 32'd3) begin
            report_error(1, $sformatf("fault count %0d, expected %0d", cnt1, cnt0 + 3));
        end
        cfg_read(mem_bus_pkg::CFG_FAULT_ADDR, faddr);
        if (faddr !== a + 32'd3) begin
            report_error(1, $sformatf("fault address %h, expected %h", faddr, a + 3));
        end
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, a, 32'h0);    // Store left no trace
        finish_test("strict alignment");
    endtask

    task automatic test_relaxed();
        logic [31:0] a;
        logic [31:0] cnt0;
        logic [31:0] cnt1;
        cfg_write(mem_bus_pkg::CFG_CTRL, 32'h0);
        tb_strict = 1'b0;
        a = tb_base + 32'h240;
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, a, $random(seed));
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, a + 4, $random(seed));
        cfg_read(mem_bus_pkg::CFG_FAULT_CNT, cnt0);
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::HALF, a + 3, 32'h0000_5a5a);
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, a + 5, $random(seed));
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, a + 1, 32'h0);
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::HALF, a + 1, 32'h0);
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, a + 7, 32'h0);
        cfg_read(mem_bus_pkg::CFG_FAULT_CNT, cnt1);
        if (cnt1 !== cnt0) begin
            report_error(1, $sformatf("fault count moved to %0d in relaxed mode", cnt1));
        end
        cfg_write(mem_bus_pkg::CFG_CTRL, 32'h1);
        tb_strict = 1'b1;
        finish_test("forced alignment");
    endtask

    task automatic test_window();
        logic [31:0] new_base;
        logic [31:0] rd;
        new_base = 32'h0002_0000;
        cfg_read(mem_bus_pkg::CFG_BASE, rd);
        if (rd !== `MEM_BASE_RESET) begin
            report_error(1, $sformatf("window base %h after reset", rd));
        end
        cfg_write(mem_bus_pkg::CFG_BASE, new_base);
        tb_base = new_base;
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, new_base + 32'h10, $random(seed));
        // Old window now lies outside the map
        access(riscv_ctrl_pkg::STORE, riscv_ctrl_pkg::WORD, `MEM_BASE_RESET + 32'h10,
               32'hdead_beef);
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, `MEM_BASE_RESET + 32'h10, 32'h0);
        access(riscv_ctrl_pkg::LOAD, riscv_ctrl_pkg::WORD, new_base + 32'h10, 32'h0);
        cfg_write(mem_bus_pkg::CFG_FAULT_CNT, 32'h0);
        cfg_read(mem_bus_pkg::CFG_FAULT_CNT, rd);
        if (rd !== 32'h0) begin
            report_error(1, $sformatf("fault count %0d after clear", rd));
        end
        cfg_write(mem_bus_pkg::CFG_BASE, `MEM_BASE_RESET);
        tb_base = `MEM_BASE_RESET;
        finish_test("window base");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed         = 53084;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        mem_en       = 1'b0;
        inst_class   = riscv_ctrl_pkg::NONE;
        mem_op       = riscv_ctrl_pkg::WORD;
        addr         = '0;
        wdata        = '0;
        cfg_we       = 1'b0;
        cfg_addr     = mem_bus_pkg::CFG_BASE;
        cfg_wdata    = '0;
        tb_base      = `MEM_BASE_RESET;
        tb_strict    = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_word_rw();
        test_sub_word();
        test_extension();
        test_strict();
        test_relaxed();
        test_window();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units, the tests did not finish",
                 WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
riscv_ctrl_pkg.sv
mem_bus_pkg.sv
access_aligner.sv
data_ram.sv
load_extender.sv
mem_cfg_regs.sv
data_mem_unit.sv
data_mem_unit_props.sv
data_mem_unit_tb.sv
